//--- ex_core.f
+incdir+.
+incdir+tests
hdl/rv_ex_pkg.sv
hdl/id_decode.sv
hdl/regfile.sv
hdl/ex_alu.sv
hdl/ex_branch.sv
hdl/ex_commit.sv
hdl/ex_core.sv
tests/tb_ex_core.sv

//--- hdl/ex_alu.sv
/*
 Integer ALU for OP, OP-IMM and LUI, fully combinational.
 Shifts use the low 5 bits of the second operand. An unknown op gives zero.
*/
`include "rv_ex_defines.svh"

module ex_alu (
    input  rv_ex_pkg::alu_op_t    alu_op,
    input  logic                  alu_use_imm,  // OP-IMM form
    input  rv_ex_pkg::word_t      rs1_data,
    input  rv_ex_pkg::word_t      rs2_data,
    input  rv_ex_pkg::imm_field_t imm_1231,
    output rv_ex_pkg::word_t      alu_result
);

    rv_ex_pkg::word_t i_imm;        // sign-extended inst[31:20]
    rv_ex_pkg::word_t op_b;
    logic [4:0]       shamt;

    assign i_imm = {{20{imm_1231[19]}}, imm_1231[19:8]};
    assign op_b  = alu_use_imm ? i_imm : rs2_data;
    assign shamt = op_b[4:0];       // imm shifts take inst[24:20]

    always_comb begin
        case (alu_op)
            `ALU_ADD:  alu_result = rs1_data + op_b;
            `ALU_SUB:  alu_result = rs1_data - op_b;
            `ALU_SLL:  alu_result = rs1_data << shamt;
            `ALU_SLT:  alu_result = {31'b0, $signed(rs1_data) < $signed(op_b)};
            `ALU_SLTU: alu_result = {31'b0, rs1_data < op_b};
            `ALU_XOR:  alu_result = rs1_data ^ op_b;
            `ALU_SRL:  alu_result = rs1_data >> shamt;
            `ALU_SRA:  alu_result = $unsigned($signed(rs1_data) >>> shamt);
            `ALU_OR:   alu_result = rs1_data | op_b;
            `ALU_AND:  alu_result = rs1_data & op_b;
            `ALU_LUI:  alu_result = {imm_1231, 12'b0};  // upper imm, low bits zero
            default:   alu_result = '0;
        endcase
    end

endmodule

//--- hdl/ex_branch.sv
/*
 Branch unit for the six conditional branches, JAL, JALR and AUIPC.
 pc_next_out is the real next pc: the target when jmp_en is high, else pc+4.
 No misaligned-target check; JALR clears bit 0 per the ISA.
*/
`include "rv_ex_defines.svh"

module ex_branch (
    input  rv_ex_pkg::word_t       pc_cur,
    input  rv_ex_pkg::word_t       rs1_data,
    input  rv_ex_pkg::word_t       rs2_data,
    input  rv_ex_pkg::reg_idx_t    rd,          // holds B-imm bits too
    input  rv_ex_pkg::imm_field_t  imm_1231,
    input  rv_ex_pkg::inst_flags_t inst_flags,
    output rv_ex_pkg::word_t       pc_next_out,
    output logic                   jmp_en,
    output rv_ex_pkg::word_t       rd_data_out,
    output logic                   rd_out_en,
    output logic                   br_claim
);

    logic [6:0]       imm_2531;     // inst[31:25]
    logic             cond_hit;     // conditional branch taken
    rv_ex_pkg::word_t pc_plus4;
    rv_ex_pkg::word_t b_target;
    rv_ex_pkg::word_t j_target;
    rv_ex_pkg::word_t r_target;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign imm_2531 = imm_1231[19:13];
    assign pc_plus4 = pc_cur + 32'd4;                   // fall-through and link
    assign b_target = pc_cur + {{20{imm_2531[6]}}, rd[0], imm_2531[5:0], rd[4:1], 1'b0};
    assign j_target = pc_cur + {{12{imm_1231[19]}}, imm_1231[7:0], imm_1231[8],
                                imm_1231[18:9], 1'b0};
    assign r_target = (rs1_data + {{20{imm_1231[19]}}, imm_1231[19:8]}) & ~32'd1;
    assign br_claim = |inst_flags[`FLAG_AUIPC:`FLAG_BEQ];

    // same priority order as the flag layout
    always_comb begin
        cond_hit = 1'b0;
        if (inst_flags[`FLAG_BEQ]) begin
            cond_hit = (rs1_data == rs2_data);
        end else if (inst_flags[`FLAG_BGE]) begin
            cond_hit = ($signed(rs1_data) >= $signed(rs2_data));
        end else if (inst_flags[`FLAG_BGEU]) begin
            cond_hit = (rs1_data >= rs2_data);
        end else if (inst_flags[`FLAG_BLT]) begin
            cond_hit = ($signed(rs1_data) < $signed(rs2_data));
        end else if (inst_flags[`FLAG_BLTU]) begin
            cond_hit = (rs1_data < rs2_data);
        end else if (inst_flags[`FLAG_BNE]) begin
            cond_hit = (rs1_data != rs2_data);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        pc_next_out = pc_plus4;     // defaults, no latches
        jmp_en      = 1'b0;
        rd_data_out = '0;
        rd_out_en   = 1'b0;
        if (|inst_flags[`FLAG_BNE:`FLAG_BEQ]) begin
            jmp_en = cond_hit;      // branches never write rd
            if (cond_hit) begin
                pc_next_out = b_target;
            end
        end else if (inst_flags[`FLAG_JALR]) begin
            pc_next_out = r_target;
            jmp_en      = 1'b1;
            rd_data_out = pc_plus4;
            rd_out_en   = 1'b1;
        end else if (inst_flags[`FLAG_JAL]) begin
            pc_next_out = j_target;
            jmp_en      = 1'b1;
            rd_data_out = pc_plus4;
            rd_out_en   = 1'b1;
        end else if (inst_flags[`FLAG_AUIPC]) begin
            rd_data_out = pc_cur + {imm_1231, 12'b0};
            rd_out_en   = 1'b1;
        end
        // priority chains above rely on a single flag
        assert final ($onehot0(inst_flags[`FLAG_AUIPC:`FLAG_BEQ]))
            else $error("branch unit got more than one flag");
    end

endmodule

//--- hdl/ex_commit.sv
/*
 Merges ALU and branch results into one commit record per instruction.
 Register write is combinational and lands on the same edge as the record.
 Writes to x0 are masked here. Record holds until the next valid instruction.
*/
module ex_commit (
    input  logic                clk,
    input  logic                rst,            // sync, active low
    input  logic                inst_valid,
    input  logic                alu_claim,
    input  rv_ex_pkg::word_t    alu_result,
    input  logic                br_claim,
    input  logic                br_jmp_en,
    input  logic                br_rd_en,
    input  rv_ex_pkg::word_t    br_pc_next,     // pc+4 when not a jump
    input  rv_ex_pkg::word_t    br_rd_data,
    input  rv_ex_pkg::reg_idx_t rd,
    output logic                wr_en,
    output rv_ex_pkg::reg_idx_t wr_idx,
    output rv_ex_pkg::word_t    wr_data,
    output logic                commit_valid,
    output logic                jmp_en,
    output rv_ex_pkg::word_t    pc_next_out,
    output logic                rd_out_en,
    output rv_ex_pkg::reg_idx_t rd_out,
    output rv_ex_pkg::word_t    rd_data_out
);

    logic jmp_c;    // jump for this instruction

    assign wr_en   = inst_valid && (alu_claim || (br_claim && br_rd_en)) && (rd != '0);
    assign wr_idx  = rd;
    assign wr_data = alu_claim ? alu_result : br_rd_data;  // branch data is 0 on no-op
    assign jmp_c   = inst_valid && br_claim && br_jmp_en;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst) begin
            commit_valid <= 1'b0;
            jmp_en       <= 1'b0;
            pc_next_out  <= '0;
            rd_out_en    <= 1'b0;
            rd_out       <= '0;
            rd_data_out  <= '0;
        end else begin
            commit_valid <= inst_valid;     // one-cycle pulse
            if (inst_valid) begin
                jmp_en      <= jmp_c;
                pc_next_out <= br_pc_next;
                rd_out_en   <= wr_en;       // x0 already masked
                rd_out      <= rd;
                rd_data_out <= wr_data;
            end
        end
    end

    // decode must route each instruction to a single unit
    a_one_claim: assert property (
        @(posedge clk) disable iff (!rst) inst_valid |-> !(alu_claim && br_claim)
    ) else $error("ALU and branch unit both claimed one instruction");

endmodule

//--- hdl/ex_core.sv
/*
 RV32I execute cluster top: decode, regfile, ALU, branch unit, commit.
 One instruction per cycle, no back-pressure; pc comes from outside and a
 redirect is only reported. Loads, stores, CSRs and traps are not handled.
*/
`include "rv_ex_defines.svh"

module ex_core (
    input  logic                clk,
    input  logic                rst,            // sync, active low
    input  logic                inst_valid,
    input  rv_ex_pkg::word_t    inst,
    input  rv_ex_pkg::word_t    pc_cur,
    output logic                commit_valid,
    output logic                jmp_en,
    output rv_ex_pkg::word_t    pc_next_out,
    output logic                rd_out_en,
    output rv_ex_pkg::reg_idx_t rd_out,
    output rv_ex_pkg::word_t    rd_data_out
);

    rv_ex_pkg::inst_flags_t inst_flags;
    rv_ex_pkg::reg_idx_t    rd;
    rv_ex_pkg::reg_idx_t    rs1;
    rv_ex_pkg::reg_idx_t    rs2;
    rv_ex_pkg::imm_field_t  imm_1231;
    rv_ex_pkg::alu_op_t     alu_op;
    logic                   alu_use_imm;
    rv_ex_pkg::word_t       rs1_data;
    rv_ex_pkg::word_t       rs2_data;
    rv_ex_pkg::word_t       alu_result;
    rv_ex_pkg::word_t       br_pc_next;     // branch unit outputs
    logic                   br_jmp_en;
    rv_ex_pkg::word_t       br_rd_data;
    logic                   br_rd_en;
    logic                   br_claim;
    logic                   wr_en;          // regfile write port
    rv_ex_pkg::reg_idx_t    wr_idx;
    rv_ex_pkg::word_t       wr_data;

    id_decode u_decode (
        .inst, .inst_flags, .rd, .rs1, .rs2, .imm_1231, .alu_op, .alu_use_imm
    );

    regfile u_regfile (
        .clk, .rst, .rs1, .rs2, .rs1_data, .rs2_data, .wr_en, .wr_idx, .wr_data
    );

    ex_alu u_alu (
        .alu_op, .alu_use_imm, .rs1_data, .rs2_data, .imm_1231, .alu_result
    );

    ex_branch u_branch (
        .pc_cur, .rs1_data, .rs2_data, .rd, .imm_1231, .inst_flags,
        .pc_next_out (br_pc_next),
        .jmp_en      (br_jmp_en),
        .rd_data_out (br_rd_data),
        .rd_out_en   (br_rd_en),
        .br_claim
    );

    ex_commit u_commit (
        .clk, .rst, .inst_valid,
        .alu_claim   (inst_flags[`FLAG_ALU]),
        .alu_result, .br_claim, .br_jmp_en, .br_rd_en, .br_pc_next, .br_rd_data,
        .rd, .wr_en, .wr_idx, .wr_data,
        .commit_valid, .jmp_en, .pc_next_out, .rd_out_en, .rd_out, .rd_data_out
    );

endmodule

//--- hdl/id_decode.sv
/*
 Purely combinational decoder for the kept RV32I subset.
 At most one flag bit is set; an unknown or illegal encoding sets none and
 then commits as a no-op. Register fields are passed out even when unused.
*/
`include "rv_ex_defines.svh"

module id_decode (
    input  rv_ex_pkg::word_t       inst,
    output rv_ex_pkg::inst_flags_t inst_flags,
    output rv_ex_pkg::reg_idx_t    rd,
    output rv_ex_pkg::reg_idx_t    rs1,
    output rv_ex_pkg::reg_idx_t    rs2,
    output rv_ex_pkg::imm_field_t  imm_1231,
    output rv_ex_pkg::alu_op_t     alu_op,
    output logic                   alu_use_imm
);

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic                 f7_zero;      // funct7 == 0000000
    logic                 f7_alt;       // funct7 == 0100000, sub / sra
    rv_ex_pkg::alu_op_t   op_f3;        // ALU op picked by funct3

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign f7_zero  = (inst[31:25] == 7'b0000000);
    assign f7_alt   = (inst[31:25] == 7'b0100000);
    assign rd       = inst[11:7];
    assign rs1      = inst[19:15];
    assign rs2      = inst[24:20];
    assign imm_1231 = inst[31:12];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (funct3)
            3'b000:  op_f3 = (opcode == `OPC_OP && f7_alt) ? `ALU_SUB : `ALU_ADD; // no subi
            3'b001:  op_f3 = `ALU_SLL;
            3'b010:  op_f3 = `ALU_SLT;
            3'b011:  op_f3 = `ALU_SLTU;
            3'b100:  op_f3 = `ALU_XOR;
            3'b101:  op_f3 = f7_alt ? `ALU_SRA : `ALU_SRL;    // inst[30] picks arith
            3'b110:  op_f3 = `ALU_OR;
            default: op_f3 = `ALU_AND;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        inst_flags  = '0;               // no-op unless matched
        alu_op      = `ALU_ADD;
        alu_use_imm = 1'b0;
        case (opcode)
            `OPC_BRANCH: begin
                case (funct3)
                    3'b000:  inst_flags[`FLAG_BEQ]  = 1'b1;
                    3'b001:  inst_flags[`FLAG_BNE]  = 1'b1;
                    3'b100:  inst_flags[`FLAG_BLT]  = 1'b1;
                    3'b101:  inst_flags[`FLAG_BGE]  = 1'b1;
                    3'b110:  inst_flags[`FLAG_BLTU] = 1'b1;
                    3'b111:  inst_flags[`FLAG_BGEU] = 1'b1;
                    default: inst_flags = '0;       // 010/011 reserved
                endcase
            end
            `OPC_JAL:   inst_flags[`FLAG_JAL]   = 1'b1;
            `OPC_JALR:  inst_flags[`FLAG_JALR]  = (funct3 == 3'b000);
            `OPC_AUIPC: inst_flags[`FLAG_AUIPC] = 1'b1;
            `OPC_LUI: begin
                inst_flags[`FLAG_ALU] = 1'b1;
                alu_op                = `ALU_LUI;
            end
            `OPC_OP: begin
                // sub and sra are the only alternate funct7 forms
                inst_flags[`FLAG_ALU] = f7_zero ||
                                        (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
                alu_op                = op_f3;
            end
            `OPC_OPIMM: begin
                alu_use_imm = 1'b1;
                alu_op      = op_f3;
                if (funct3 == 3'b001) begin
                    inst_flags[`FLAG_ALU] = f7_zero;            // slli
                end else if (funct3 == 3'b101) begin
                    inst_flags[`FLAG_ALU] = f7_zero || f7_alt;  // srli / srai
                end else begin
                    inst_flags[`FLAG_ALU] = 1'b1;               // imm fills 31..20
                end
            end
            default: inst_flags = '0;
        endcase
    end

endmodule

//--- hdl/regfile.sv
/*
 32 x 32 register file, x0 has no storage and always reads zero.
 Reads are combinational, so a write lands in time for the next
 instruction without any bypass. Reset clears x1..x31.
*/
module regfile (
    input  logic                clk,
    input  logic                rst,        // sync, active low
    input  rv_ex_pkg::reg_idx_t rs1,
    input  rv_ex_pkg::reg_idx_t rs2,
    output rv_ex_pkg::word_t    rs1_data,
    output rv_ex_pkg::word_t    rs2_data,
    input  logic                wr_en,
    input  rv_ex_pkg::reg_idx_t wr_idx,
    input  rv_ex_pkg::word_t    wr_data
);

    rv_ex_pkg::word_t regs [1:31];          // x1..x31 only

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // x0 reads as zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    // commit stage is expected to mask x0 writes before they get here
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (!rst) wr_en |-> (wr_idx != '0)
    ) else $error("write to x0 reached the register file");

endmodule

//--- hdl/rv_ex_pkg.sv
/*
 Vector types shared by the execute cluster and its testbench.
 The flag vector width comes from the defines header.
*/
`include "rv_ex_defines.svh"

package rv_ex_pkg;

    // data word, also used for pc values
    typedef logic [31:0] word_t;

    typedef logic [4:0] reg_idx_t;      // x0..x31

    // raw inst[31:12], the branch unit rebuilds every immediate from it
    typedef logic [19:0] imm_field_t;

    typedef logic [`INST_FLAGS_W-1:0] inst_flags_t;  // one-hot, zero for no-op

    typedef logic [3:0] alu_op_t;       // ALU_* codes

endpackage

//--- run.sh
#!/bin/sh
# build and run the execute cluster testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_ex_core \
    -Mdir obj_dir -o sim_ex_core -f ex_core.f
./obj_dir/sim_ex_core > sim.log 2>&1 || true
cat sim.log
if grep -q "TB FAILED" sim.log || ! grep -q "TB PASSED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- rv_ex_defines.svh
/*
 Flag bits 0..8 keep the branch-unit layout; bit 9 marks an ALU instruction.
 Opcode values are the RV32I major opcodes, bits 6..0 of the word.
 Only the kept subset of RV32I is listed here.
*/
`ifndef RV_EX_DEFINES_SVH
`define RV_EX_DEFINES_SVH

`define INST_FLAGS_W 48         // room left for other units

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define FLAG_BEQ   0
`define FLAG_BGE   1
`define FLAG_BGEU  2
`define FLAG_BLT   3
`define FLAG_BLTU  4
`define FLAG_BNE   5
`define FLAG_JALR  6
`define FLAG_JAL   7
`define FLAG_AUIPC 8
`define FLAG_ALU   9            // OP, OP-IMM, LUI

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_AUIPC  7'b0010111
`define OPC_LUI    7'b0110111
`define OPC_OP     7'b0110011
`define OPC_OPIMM  7'b0010011

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define ALU_ADD  4'd0
`define ALU_SUB  4'd1
`define ALU_SLL  4'd2
`define ALU_SLT  4'd3
`define ALU_SLTU 4'd4
`define ALU_XOR  4'd5
`define ALU_SRL  4'd6
`define ALU_SRA  4'd7
`define ALU_OR   4'd8
`define ALU_AND  4'd9
`define ALU_LUI  4'd10          // passes the U-immediate

`endif

//--- tests/ex_ref_model.svh
/*
 Reference model of the execute cluster, written from the RV32I encodings.
 The shadow register file is updated in issue order. This matches the DUT
 because each write lands before the next instruction reads.
 Only legal encodings of the kept opcodes are modelled, anything else is a no-op.
*/
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

`include "rv_ex_defines.svh"

typedef struct packed {
    logic                jmp;
    rv_ex_pkg::word_t    pc_next;
    logic                rd_en;
    rv_ex_pkg::reg_idx_t rd;
    rv_ex_pkg::word_t    rd_data;
    logic [31:0]         due;           // falling edge where the commit shows
} commit_rec_t;

rv_ex_pkg::word_t shadow [32] = '{default: '0};    // x0 never written

function automatic rv_ex_pkg::word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

// expected commit record for one instruction, updates the shadow regs
function automatic commit_rec_t predict_commit(input rv_ex_pkg::word_t w,
                                               input rv_ex_pkg::word_t pc);
    commit_rec_t      r;
    rv_ex_pkg::word_t a;
    rv_ex_pkg::word_t b;
    logic [2:0]       f3;
    logic             wr;               // instruction targets rd
    a  = shadow[w[19:15]];
    b  = (w[6:0] == `OPC_OPIMM) ? sext12(w[31:20]) : shadow[w[24:20]];
    f3 = w[14:12];
    wr = 1'b0;
    r  = '0;
    r.pc_next = pc + 32'd4;             // fall-through
    r.rd      = w[11:7];
    case (w[6:0])
        `OPC_OP, `OPC_OPIMM: begin
            wr = 1'b1;
            case (f3)
                3'b000:  r.rd_data = (w[6:0] == `OPC_OP && w[30]) ? a - b : a + b;
                3'b001:  r.rd_data = a << b[4:0];
                3'b010:  r.rd_data = {31'b0, $signed(a) < $signed(b)};
                3'b011:  r.rd_data = {31'b0, a < b};
                3'b100:  r.rd_data = a ^ b;
                3'b101: begin
                    if (w[30]) begin
                        r.rd_data = $signed(a) >>> b[4:0];  // sra / srai
                    end else begin
                        r.rd_data = a >> b[4:0];
                    end
                end
                3'b110:  r.rd_data = a | b;
                default: r.rd_data = a & b;
            endcase
        end
        `OPC_LUI: begin
            wr        = 1'b1;
            r.rd_data = {w[31:12], 12'b0};
        end
        `OPC_AUIPC: begin
            wr        = 1'b1;
            r.rd_data = pc + {w[31:12], 12'b0};
        end
        `OPC_JAL: begin
            wr        = 1'b1;
            r.jmp     = 1'b1;
            r.rd_data = pc + 32'd4;     // link
            r.pc_next = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        `OPC_JALR: begin
            wr        = 1'b1;
            r.jmp     = 1'b1;
            r.rd_data = pc + 32'd4;
            r.pc_next = (a + sext12(w[31:20])) & ~32'd1;
        end
        `OPC_BRANCH: begin
            case (f3)
                3'b000:  r.jmp = (a == b);
                3'b001:  r.jmp = (a != b);
                3'b100:  r.jmp = ($signed(a) < $signed(b));
                3'b101:  r.jmp = ($signed(a) >= $signed(b));
                3'b110:  r.jmp = (a < b);
                default: r.jmp = (a >= b);  // bgeu
            endcase
            if (r.jmp) begin
                r.pc_next = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
        end
        default: r.jmp = 1'b0;          // unknown opcode commits as no-op
    endcase
    r.rd_en = wr && (r.rd != 5'd0);
    if (r.rd_en) begin
        shadow[r.rd] = r.rd_data;
    end
    return r;
endfunction

`endif

//--- tests/tb_ex_core.sv
/*
 Testbench for the execute cluster top level.
 Inputs change on the rising edge, outputs are sampled on the falling edge.
 Stops at the first mismatch; every wait is bounded to 20 cycles.
*/
module tb_ex_core;
    timeunit 1ns;
    timeprecision 100ps;

    `include "ex_ref_model.svh"

    logic                clk;
    logic                rst;
    logic                inst_valid;
    rv_ex_pkg::word_t    inst;
    rv_ex_pkg::word_t    pc_cur;
    logic                commit_valid;
    logic                jmp_en;
    rv_ex_pkg::word_t    pc_next_out;
    logic                rd_out_en;
    rv_ex_pkg::reg_idx_t rd_out;
    rv_ex_pkg::word_t    rd_data_out;

    integer      seed;
    logic [31:0] neg_cnt = '0;          // falling edges seen so far
    string       test_name = "none";
    commit_rec_t exp_q [$];             // expected commits in order

    ex_core uut (.*);

    always #10 clk = ~clk;              // 20 ns period

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic fail_value(input string what, input rv_ex_pkg::word_t exp,
                              input rv_ex_pkg::word_t act);
        $display("error %s: %s expected %h actual %h", test_name, what, exp, act);
        $display("TB FAILED");
        $fatal(1, "mismatch on %s", what);
    endtask

    task automatic fail_text(input string msg);
        $display("%s (%s)", msg, test_name);
        $display("TB FAILED");
        $fatal(1, "%s", msg);
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // instruction encoders
    function automatic rv_ex_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic rv_ex_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv_ex_pkg::word_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                               input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic rv_ex_pkg::word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    function automatic rv_ex_pkg::word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic issue(input rv_ex_pkg::word_t w, input rv_ex_pkg::word_t pc);
        commit_rec_t r;
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= w;
        pc_cur     <= pc;
        r     = predict_commit(w, pc);
        r.due = neg_cnt + 32'd2;        // sampled next edge, seen one edge later
        exp_q.push_back(r);
    endtask

    task automatic drain();             // end a burst, wait for its commits
        int n;
        @(posedge clk);
        inst_valid <= 1'b0;
        n = 0;
        while (exp_q.size() != 0 && n < 20) begin
            @(posedge clk);
            n++;
        end
        assert (exp_q.size() == 0) else fail_text("timeout waiting for commit");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : compare
        commit_rec_t e;
        forever begin
            @(negedge clk);
            neg_cnt++;
            if (rst && commit_valid) begin
                assert (exp_q.size() != 0) else fail_text("commit with nothing issued");
                e = exp_q.pop_front();
                assert (neg_cnt == e.due) else fail_value("commit edge", e.due, neg_cnt);
                assert (jmp_en == e.jmp) else fail_value("jmp_en", 32'(e.jmp), 32'(jmp_en));
                assert (pc_next_out == e.pc_next)
                    else fail_value("pc_next_out", e.pc_next, pc_next_out);
                assert (rd_out_en == e.rd_en)
                    else fail_value("rd_out_en", 32'(e.rd_en), 32'(rd_out_en));
                assert (rd_out == e.rd) else fail_value("rd_out", 32'(e.rd), 32'(rd_out));
                if (e.rd_en) begin      // data only defined with a write
                    assert (rd_data_out == e.rd_data)
                        else fail_value("rd_data_out", e.rd_data, rd_data_out);
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : stimulus
        rv_ex_pkg::word_t pc;
        rv_ex_pkg::word_t w;
        logic [31:0]      rw;
        logic [4:0]       ra;
        logic [4:0]       rb;
        logic [4:0]       rc;
        logic [2:0]       f3;
        logic             alt;          // sub / sra form
        seed       = 19;
        clk        = 1'b0;
        rst        = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        pc_cur     = '0;
        pc         = 32'h0000_1000;
        repeat (16) @(posedge clk);
        rst <= 1'b1;

        test_name = "reset_idle";
        repeat (8) begin
            @(negedge clk);
            assert (!commit_valid && !jmp_en && !rd_out_en && pc_next_out == '0 &&
                    rd_data_out == '0) else fail_text("commit outputs not cleared by reset");
        end

        test_name = "reg_load";         // x1..x31 from x0
        for (int i = 1; i < 32; i++) begin
            if (i % 4 == 0) begin
                issue(enc_u(20'(rand_word() >> 12), 5'(i), `OPC_LUI), pc);
            end else begin
                issue(enc_i(12'(rand_word()), 5'd0, 3'b000, 5'(i), `OPC_OPIMM), pc);
            end
            pc += 4;
        end
        drain();

        test_name = "alu_random";       // random regs give back-to-back deps
        for (int i = 0; i < 80; i++) begin
            rw  = rand_word();
            f3  = rw[2:0];
            alt = rw[3] && (f3 == 3'b000 || f3 == 3'b101);
            ra  = rw[9:5];
            rb  = rw[14:10];
            rc  = rw[19:15];
            if (!rw[4]) begin
                w = enc_r({1'b0, alt, 5'b0}, rb, ra, f3, rc, `OPC_OP);
            end else if (f3 == 3'b001 || f3 == 3'b101) begin
                w = enc_i({1'b0, alt, 5'b0, rw[24:20]}, ra, f3, rc, `OPC_OPIMM);
            end else begin
                w = enc_i(rw[31:20], ra, f3, rc, `OPC_OPIMM);
            end
            issue(w, pc);
            pc += 4;
        end
        for (int i = 0; i < 6; i++) begin   // explicit chain on x7
            issue(enc_r({1'b0, i[0], 5'b0}, 5'd8, 5'd7, 3'b000, 5'd7, `OPC_OP), pc);
            pc += 4;
        end
        drain();

        test_name = "branch";
        issue(enc_i(12'h5a5, 5'd0, 3'b000, 5'd12, `OPC_OPIMM), pc);
        issue(enc_i(12'h5a5, 5'd0, 3'b000, 5'd13, `OPC_OPIMM), pc + 4);
        pc = rand_word() & ~32'd3;
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3) begin
                continue;               // reserved funct3
            end
            for (int k = 0; k < 6; k++) begin
                rw = rand_word();
                ra = (k == 2) ? 5'd12 : rw[4:0];
                rb = (k == 1) ? ra : (k == 2) ? 5'd13 : rw[9:5];
                issue(enc_b({rw[31:20], 1'b0}, rb, ra, 3'(f)), pc);
                pc += 4;
            end
        end
        drain();

        test_name = "jal_jalr";
        for (int k = 0; k < 12; k++) begin
            rw = rand_word();
            rc = (k % 4 == 0) ? 5'd0 : rw[4:0];     // some links to x0
            if (k[0]) begin
                w = enc_i(rw[31:20], rw[9:5], 3'b000, rc, `OPC_JALR);
            end else begin
                w = enc_j({rw[31:12], 1'b0}, rc);
            end
            issue(w, pc);
            pc += 4;
        end
        drain();

        test_name = "auipc_unknown";
        for (int k = 0; k < 8; k++) begin
            rw = rand_word();
            issue(enc_u(rw[31:12], rw[11:7], `OPC_AUIPC), pc);
            issue({rw[31:7], (k[0] ? 7'b0000011 : 7'b1110011)}, pc + 4);  // load, system
            pc += 8;
        end
        drain();

        test_name = "reg_sweep";        // addi xi, xi, 0 reads back each reg
        for (int i = 1; i < 32; i++) begin
            issue(enc_i(12'd0, 5'(i), 3'b000, 5'(i), `OPC_OPIMM), pc);
            pc += 4;
        end
        drain();

        $display("TB PASSED");
        $finish;
    end

endmodule
